// ==== logic/des_macros.svh ====
`ifndef DES_MACROS_SVH
`define DES_MACROS_SVH

// Data block and key width
`define DES_BLOCK_W 64
`define DES_HALF_W 32
`define DES_CD_W 28
`define DES_SUBKEY_W 48

// Round control
`define DES_ROUNDS 16
`define DES_ROUND_IDX_W 5

`endif

// ==== logic/des_pkg.sv ====
`include "des_macros.svh"

package des_pkg;

  typedef struct packed {
    logic [`DES_HALF_W-1:0] l;
    logic [`DES_HALF_W-1:0] r;
  } des_halves_t;

  typedef struct packed {
    logic [`DES_CD_W-1:0] c;
    logic [`DES_CD_W-1:0] d;
  } des_cd_t;

  // chunk[0] feeds S1, chunk[7] feeds S8
  typedef union packed {
    logic [`DES_SUBKEY_W-1:0] word;
    logic [0:7][5:0]          chunk;
  } des_sbox_in_u;

endpackage

// ==== logic/des_input_stage.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_input_stage
  import des_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic [`DES_BLOCK_W-1:0] message,
  input  logic [`DES_BLOCK_W-1:0] key,
  input  logic                    done,
  output logic                    load,
  output des_halves_t             block,
  output des_cd_t                 cd,
  output logic                    busy
);

  localparam int IP_TBL [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,
    60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,
    64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1,
    59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,
    63, 55, 47, 39, 31, 23, 15, 7
  };

  // Parity bits 8, 16, .. 64 are dropped here
  localparam int PC1_TBL [56] = '{
    57, 49, 41, 33, 25, 17,  9,
     1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27,
    19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,
     7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29,
    21, 13,  5, 28, 20, 12,  4
  };

  logic [`DES_BLOCK_W-1:0]  msg_ip;
  logic [2*`DES_CD_W-1:0]   key_pc1;
  logic                     accept;

  assign accept = start & ~busy; // Start while busy is dropped

  always_comb
  begin
    for (int i = 0; i < 64; i++)
    begin
      msg_ip[`DES_BLOCK_W-1-i] = message[`DES_BLOCK_W-IP_TBL[i]];
    end
    for (int i = 0; i < 56; i++)
    begin
      key_pc1[2*`DES_CD_W-1-i] = key[`DES_BLOCK_W-PC1_TBL[i]];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      load <= 1'b0;
      busy <= 1'b0;
    end
    else
    begin
      load <= accept;
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      block <= msg_ip;
      cd    <= key_pc1;
    end
  end

  a_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> busy);

endmodule

// ==== logic/des_key_schedule.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_key_schedule
  import des_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load,
  input  des_cd_t                     cd,
  input  logic                        step,
  input  logic [`DES_ROUND_IDX_W-1:0] round_idx,
  output logic [`DES_SUBKEY_W-1:0]    subkey
);

  localparam int PC2_TBL [48] = '{
    14, 17, 11, 24,  1,  5,
     3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8,
    16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55,
    30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53,
    46, 42, 50, 36, 29, 32
  };

  // Bit set means rotate by two in that round
  localparam logic [1:`DES_ROUNDS] ROT2 = 16'b0011_1111_0111_1110;

  logic [`DES_CD_W-1:0]   c_q;
  logic [`DES_CD_W-1:0]   d_q;
  logic [`DES_CD_W-1:0]   c_rot;
  logic [`DES_CD_W-1:0]   d_rot;
  logic [2*`DES_CD_W-1:0] cd_rot;

  always_comb
  begin
    if (ROT2[round_idx])
    begin
      c_rot = {c_q[`DES_CD_W-3:0], c_q[`DES_CD_W-1 -: 2]};
      d_rot = {d_q[`DES_CD_W-3:0], d_q[`DES_CD_W-1 -: 2]};
    end
    else
    begin
      c_rot = {c_q[`DES_CD_W-2:0], c_q[`DES_CD_W-1]};
      d_rot = {d_q[`DES_CD_W-2:0], d_q[`DES_CD_W-1]};
    end
    cd_rot = {c_rot, d_rot};
    for (int i = 0; i < `DES_SUBKEY_W; i++)
    begin
      subkey[`DES_SUBKEY_W-1-i] = cd_rot[2*`DES_CD_W-PC2_TBL[i]];
    end
  end

  // Key material is cleared on reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      c_q <= '0;
      d_q <= '0;
    end
    else if (load)
    begin
      c_q <= cd.c;
      d_q <= cd.d;
    end
    else if (step)
    begin
      c_q <= c_rot; // Rotation of this round carries to the next
      d_q <= d_rot;
    end
  end

  a_step_idx: assert property (@(posedge clk) disable iff (!arst_n)
    step |-> (round_idx >= 1 && round_idx <= `DES_ROUNDS));

endmodule

// ==== logic/des_feistel_f.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_feistel_f
  import des_pkg::*;
(
  input  logic [`DES_HALF_W-1:0]   r,
  input  logic [`DES_SUBKEY_W-1:0] subkey,
  output logic [`DES_HALF_W-1:0]   f
);

  localparam int E_TBL [48] = '{
    32,  1,  2,  3,  4,  5,
     4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13,
    12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21,
    20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29,
    28, 29, 30, 31, 32,  1
  };

  localparam int P_TBL [32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,
     1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9,
    19, 13, 30,  6, 22, 11,  4, 25
  };

  // One box per 256-bit word, four rows of sixteen nibbles each
  localparam logic [0:7][0:63][3:0] SBOX = {
    256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
    256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
    256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
    256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
    256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
    256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
    256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
    256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
  };

  logic [`DES_SUBKEY_W-1:0] r_exp;
  des_sbox_in_u             sin;
  logic [0:7][3:0]          s_out;
  logic [`DES_HALF_W-1:0]   s_flat;

  always_comb
  begin
    for (int i = 0; i < `DES_SUBKEY_W; i++)
    begin
      r_exp[`DES_SUBKEY_W-1-i] = r[`DES_HALF_W-E_TBL[i]];
    end
    sin.word = r_exp ^ subkey;
    // Row from outer bits, column from inner four
    for (int n = 0; n < 8; n++)
    begin
      s_out[n] = SBOX[n][{sin.chunk[n][5], sin.chunk[n][0], sin.chunk[n][4:1]}];
    end
    s_flat = s_out;
    for (int i = 0; i < `DES_HALF_W; i++)
    begin
      f[`DES_HALF_W-1-i] = s_flat[`DES_HALF_W-P_TBL[i]];
    end
  end

endmodule

// ==== logic/des_round_engine.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_round_engine
  import des_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load,
  input  des_halves_t                 block,
  input  logic [`DES_SUBKEY_W-1:0]    subkey,
  output logic                        step,
  output logic [`DES_ROUND_IDX_W-1:0] round_idx,
  output logic                        rounds_done,
  output des_halves_t                 result
);

  des_halves_t            lr_q;
  logic                   running;
  logic                   last_round;
  logic [`DES_HALF_W-1:0] f_val;

  des_feistel_f u_feistel (
    .r      (lr_q.r),
    .subkey (subkey),
    .f      (f_val)
  );

  assign step       = running;
  assign last_round = (int'(round_idx) == `DES_ROUNDS);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      running     <= 1'b0;
      round_idx   <= '0;
      rounds_done <= 1'b0;
    end
    else
    begin
      rounds_done <= step & last_round;
      if (load)
      begin
        running   <= 1'b1;
        round_idx <= `DES_ROUND_IDX_W'(1);
      end
      else if (step)
      begin
        if (last_round)
        begin
          running   <= 1'b0;
          round_idx <= '0;
        end
        else
          round_idx <= round_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      lr_q <= block;
    else if (step)
      lr_q <= '{l: lr_q.r, r: lr_q.l ^ f_val};
  end

  assign result = '{l: lr_q.r, r: lr_q.l}; // R16 L16 for the final permutation

  a_no_load_busy: assert property (@(posedge clk) disable iff (!arst_n)
    load |-> !running);

endmodule

// ==== logic/des_output_stage.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_output_stage
  import des_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    rounds_done,
  input  des_halves_t             result,
  output logic [`DES_BLOCK_W-1:0] ciphertext,
  output logic                    done
);

  localparam int IP_INV_TBL [64] = '{
    40,  8, 48, 16, 56, 24, 64, 32,
    39,  7, 47, 15, 55, 23, 63, 31,
    38,  6, 46, 14, 54, 22, 62, 30,
    37,  5, 45, 13, 53, 21, 61, 29,
    36,  4, 44, 12, 52, 20, 60, 28,
    35,  3, 43, 11, 51, 19, 59, 27,
    34,  2, 42, 10, 50, 18, 58, 26,
    33,  1, 41,  9, 49, 17, 57, 25
  };

  logic [`DES_BLOCK_W-1:0] pre_out;
  logic [`DES_BLOCK_W-1:0] ct_next;

  assign pre_out = result;

  always_comb
  begin
    for (int i = 0; i < 64; i++)
    begin
      ct_next[`DES_BLOCK_W-1-i] = pre_out[`DES_BLOCK_W-IP_INV_TBL[i]];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ciphertext <= '0;
      done       <= 1'b0;
    end
    else
    begin
      done <= rounds_done;
      if (rounds_done)
        ciphertext <= ct_next; // Held until the next block finishes
    end
  end

endmodule

// ==== logic/des_ecb_enc.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module des_ecb_enc
  import des_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  logic [`DES_BLOCK_W-1:0] message,
  input  logic [`DES_BLOCK_W-1:0] key,
  output logic [`DES_BLOCK_W-1:0] ciphertext,
  output logic                    done,
  output logic                    busy
);

  logic                        load;
  des_halves_t                 block;
  des_cd_t                     cd;
  logic                        step;
  logic [`DES_ROUND_IDX_W-1:0] round_idx;
  logic [`DES_SUBKEY_W-1:0]    subkey;
  logic                        rounds_done;
  des_halves_t                 result;

  des_input_stage u_input (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .message (message),
    .key     (key),
    .done    (done),
    .load    (load),
    .block   (block),
    .cd      (cd),
    .busy    (busy)
  );

  des_key_schedule u_keys (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .cd        (cd),
    .step      (step),
    .round_idx (round_idx),
    .subkey    (subkey)
  );

  des_round_engine u_rounds (
    .clk         (clk),
    .arst_n      (arst_n),
    .load        (load),
    .block       (block),
    .subkey      (subkey),
    .step        (step),
    .round_idx   (round_idx),
    .rounds_done (rounds_done),
    .result      (result)
  );

  des_output_stage u_output (
    .clk         (clk),
    .arst_n      (arst_n),
    .rounds_done (rounds_done),
    .result      (result),
    .ciphertext  (ciphertext),
    .done        (done)
  );

endmodule

// ==== verif/tb_des_ecb_enc.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module tb_des_ecb_enc;

  localparam int LATENCY = `DES_ROUNDS + 2;    // Start edge to done edge
  localparam int NUM_ENC = 20;                 // 3 known answers, 16 complement, 1 busy
  localparam int TIMEOUT = 20 * NUM_ENC + 50;
  localparam logic [63:0] KAT1_KEY = 64'h133457799BBCDFF1;
  localparam logic [63:0] KAT1_MSG = 64'h0123456789ABCDEF;
  localparam logic [63:0] KAT1_CT  = 64'h85E813540F0AB405;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        start;
  logic [63:0] message;
  logic [63:0] key;
  logic [63:0] ciphertext;
  logic        done;
  logic        busy;

  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          age = 0;                        // Cycles since the last accepted start
  logic [15:0] lfsr = 16'd52686;
  logic        busy_exp;
  logic        done_exp;
  logic        accepted;

  des_ecb_enc uut (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .message    (message),
    .key        (key),
    .ciphertext (ciphertext),
    .done       (done),
    .busy       (busy)
  );

  always #4 clk = ~clk;

  assign busy_exp = (age >= 1 && age <= LATENCY + 1);
  assign done_exp = (age == LATENCY + 1);
  assign accepted = start && !busy_exp;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (accepted)
      age <= 1;
    else if (age != 0 && age <= LATENCY + 1)
      age <= age + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Finished with errors");
      $finish;
    end
  end

  a_busy: assert property (@(posedge clk) disable iff (!arst_n) busy == busy_exp)
    else
    begin
      $display("mismatch at %0t: busy got %b expected %b", $time, $sampled(busy),
               $sampled(busy_exp));
      errors++;
    end

  // Also covers the one-cycle width and a done from a dropped start
  a_done: assert property (@(posedge clk) disable iff (!arst_n) done == done_exp)
    else
    begin
      $display("mismatch at %0t: done got %b expected %b", $time, $sampled(done),
               $sampled(done_exp));
      errors++;
    end

  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(ciphertext) |-> done)
    else
    begin
      $display("ciphertext changed at %0t outside a done cycle", $time);
      errors++;
    end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic rand_word(output logic [63:0] w);
    for (int i = 0; i < 64; i++)
    begin
      lfsr = lfsr_next(lfsr);
      w = {w[62:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before)
    begin
      tests_passed++;
      $display("test %s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: fail", name);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after busy drops
  task automatic encrypt(input logic [63:0] k, input logic [63:0] m, output logic [63:0] c);
    key = k;
    message = m;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!done)
      @(negedge clk);
    c = ciphertext;
    while (busy)
      @(negedge clk);
  endtask

  initial
  begin
    logic [63:0] k;
    logic [63:0] m;
    logic [63:0] c1;
    logic [63:0] c2;
    int          errs;
    int          extra;
    arst_n = 1'b0;
    start = 1'b0;
    message = '0;
    key = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    errs = errors;
    check_value("done", done, 0);
    check_value("busy", busy, 0);
    check_value("ciphertext", ciphertext, 0);
    finish_test("reset state", errs);

    errs = errors;
    encrypt(KAT1_KEY, KAT1_MSG, c1);
    check_value("ciphertext", c1, KAT1_CT);
    encrypt(64'h0E329232EA6D0D73, 64'h8787878787878787, c1);
    check_value("ciphertext", c1, 64'h0000000000000000);
    encrypt(64'h0, 64'h0, c1);
    check_value("ciphertext", c1, 64'h8CA64DE9C1B123A7);
    finish_test("known answers", errs);

    errs = errors;
    for (int i = 0; i < 8; i++)
    begin
      rand_word(k);
      rand_word(m);
      encrypt(k, m, c1);
      encrypt(~k, ~m, c2);
      check_value("ciphertext", c2, ~c1);
    end
    finish_test("complementation", errs);

    errs = errors;
    key = KAT1_KEY;
    message = KAT1_MSG;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (5) @(negedge clk);
    key = '0;                                  // Second start lands mid-block
    message = '1;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!done)
      @(negedge clk);
    check_value("ciphertext", ciphertext, KAT1_CT);
    extra = 0;
    repeat (20)
    begin
      @(negedge clk);
      if (done)
        extra++;
    end
    check_value("extra done count", extra, 0);
    finish_test("start while busy", errs);

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0 && tests_failed == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/des_pkg.sv
logic/des_input_stage.sv
logic/des_key_schedule.sv
logic/des_feistel_f.sv
logic/des_round_engine.sv
logic/des_output_stage.sv
logic/des_ecb_enc.sv
verif/tb_des_ecb_enc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_des_ecb_enc
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/des_macros.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
